// File: decode_pkg.sv
// Widths, types and opcode constants shared by the decode pipeline RTL and its testbench
`default_nettype none

package decode_pkg;

  localparam int INSTR_W  = 16;
  localparam int OPC_W    = 4;
  localparam int REG_AD_W = 3;
  localparam int COND_W   = 3;
  localparam int ALU_OP_W = 3;

  // Control word packs, from MSB down: input_sel, wren, write_ad, adr_mux, write,
  // pc_load, spr_w, spr_i, spr_d, cond, op2, sw, mad_mux
  localparam int CTRL_W = 19;

  typedef logic [INSTR_W-1:0]  instr_t;
  typedef logic [OPC_W-1:0]    opcode_t;
  typedef logic [REG_AD_W-1:0] reg_addr_t;
  typedef logic [COND_W-1:0]   cond_t;
  typedef logic [ALU_OP_W-1:0] alu_op_t;
  typedef logic [CTRL_W-1:0]   ctrl_word_t;

  // Lowest bit of each instruction field
  localparam int OPC_LSB  = 12;
  localparam int RD_LSB   = 9;
  localparam int COND_LSB = 6;
  localparam int ALU_LSB  = 3;

  // Opcodes, values 8 to 15 are illegal and decode like NOP
  localparam opcode_t OP_NOP   = 4'd0;
  localparam opcode_t OP_ALU   = 4'd1;
  localparam opcode_t OP_LOAD  = 4'd2;
  localparam opcode_t OP_STORE = 4'd3;
  localparam opcode_t OP_IN    = 4'd4;
  localparam opcode_t OP_JUMP  = 4'd5;
  localparam opcode_t OP_PUSH  = 4'd6;
  localparam opcode_t OP_POP   = 4'd7;

endpackage

`default_nettype wire

// File: ctrl_if.sv
// Control word bus with valid/ready between the decoder and the issue stage
`timescale 1ns/1ns
`default_nettype none

interface ctrl_if;

  logic                  valid;
  logic                  ready;
  logic                  input_sel;
  logic                  wren;
  decode_pkg::reg_addr_t write_ad;
  logic                  adr_mux;
  logic                  write;
  logic                  pc_load;
  logic                  spr_w;
  logic                  spr_i;
  logic                  spr_d;
  decode_pkg::cond_t     cond;
  decode_pkg::alu_op_t   op2;
  logic                  sw;
  logic                  mad_mux;

  modport producer (
    output valid, input_sel, wren, write_ad, adr_mux, write, pc_load,
    output spr_w, spr_i, spr_d, cond, op2, sw, mad_mux,
    input  ready
  );

  modport consumer (
    input  valid, input_sel, wren, write_ad, adr_mux, write, pc_load,
    input  spr_w, spr_i, spr_d, cond, op2, sw, mad_mux,
    output ready
  );

endinterface

`default_nettype wire

// File: instr_intake.sv
// Fetch-side four-phase receiver with a small FIFO that feeds the decoder over valid/ready
`timescale 1ns/1ns
`default_nettype none

module instr_intake #(
  parameter int INTAKE_DEPTH = 2
) (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               instr_req,
  input  decode_pkg::instr_t instr,
  output logic               instr_ack,
  output logic               dec_valid,
  output decode_pkg::instr_t dec_instr,
  input  logic               dec_ready
);

  localparam int PTR_W = (INTAKE_DEPTH > 1) ? $clog2(INTAKE_DEPTH) : 1;
  localparam int CNT_W = $clog2(INTAKE_DEPTH + 1);

  typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} state_t;

  state_t             state;
  decode_pkg::instr_t mem [INTAKE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               fifo_full;
  logic               fifo_wr;
  logic               fifo_rd;

  assign fifo_full = (count == CNT_W'(INTAKE_DEPTH));
  // Capture only from IDLE, so each request is stored exactly once
  assign fifo_wr   = (state == IDLE) && instr_req && !fifo_full;
  assign fifo_rd   = dec_valid && dec_ready;
  assign instr_ack = (state != IDLE);
  assign dec_valid = (count != '0);
  assign dec_instr = mem[rd_ptr];

  // ACK is the first acknowledge cycle, WAIT_LOW holds ack until fetch drops req
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:     if (fifo_wr) state <= ACK;
        ACK:      state <= instr_req ? WAIT_LOW : IDLE;
        WAIT_LOW: if (!instr_req) state <= IDLE;
        default:  state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (fifo_wr) begin
      mem[wr_ptr] <= instr;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(INTAKE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (fifo_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(INTAKE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({fifo_wr, fifo_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Ack may only follow a request that was already high
  a_ack_after_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(instr_ack) |-> $past(instr_req))
    else $error("instr_ack rose without instr_req");

  // A new ack marks a stored word, so the FIFO had a free slot at that edge
  a_no_write_full: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(instr_ack) |-> ($past(count) < CNT_W'(INTAKE_DEPTH)))
    else $error("intake FIFO written while full");

endmodule

`default_nettype wire

// File: control_decoder.sv
// Opcode decode into register one, then a one-cycle copy into register two that drives the bus
`timescale 1ns/1ns
`default_nettype none

module control_decoder (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               dec_valid,
  input  decode_pkg::instr_t dec_instr,
  output logic               dec_ready,
  ctrl_if.producer           out
);

  decode_pkg::ctrl_word_t r1_word;
  decode_pkg::ctrl_word_t r2_word;
  logic                   r1_valid;
  logic                   r2_valid;
  logic                   r1_load;
  logic                   r2_load;

  function automatic decode_pkg::ctrl_word_t decode(input decode_pkg::instr_t ins);
    decode_pkg::opcode_t   opc;
    decode_pkg::reg_addr_t rd;
    decode_pkg::cond_t     cnd;
    decode_pkg::alu_op_t   aop;
    decode_pkg::reg_addr_t write_ad;
    decode_pkg::cond_t     cond;
    decode_pkg::alu_op_t   op2;
    logic input_sel;
    logic wren;
    logic adr_mux;
    logic write;
    logic pc_load;
    logic spr_w;
    logic spr_i;
    logic spr_d;
    logic sw;
    logic mad_mux;
    opc = ins[decode_pkg::OPC_LSB +: decode_pkg::OPC_W];
    rd  = ins[decode_pkg::RD_LSB +: decode_pkg::REG_AD_W];
    cnd = ins[decode_pkg::COND_LSB +: decode_pkg::COND_W];
    aop = ins[decode_pkg::ALU_LSB +: decode_pkg::ALU_OP_W];
    {input_sel, wren, write_ad, adr_mux, write, pc_load,
     spr_w, spr_i, spr_d, cond, op2, sw, mad_mux} = '0;
    case (opc)
      decode_pkg::OP_ALU: begin
        wren     = 1'b1;
        write_ad = rd;
        op2      = aop;
      end
      decode_pkg::OP_LOAD: begin
        wren     = 1'b1;
        write_ad = rd;
        adr_mux  = 1'b1;
        mad_mux  = 1'b1;
      end
      decode_pkg::OP_STORE: begin
        write   = 1'b1;
        adr_mux = 1'b1;
      end
      decode_pkg::OP_IN: begin
        input_sel = 1'b1;
        wren      = 1'b1;
        write_ad  = rd;
      end
      decode_pkg::OP_JUMP: begin
        pc_load = 1'b1;
        cond    = cnd;
      end
      decode_pkg::OP_PUSH: begin
        spr_w = 1'b1;
        spr_d = 1'b1;
        write = 1'b1;
        sw    = 1'b1;
      end
      decode_pkg::OP_POP: begin
        spr_w    = 1'b1;
        spr_i    = 1'b1;
        wren     = 1'b1;
        write_ad = rd;
        mad_mux  = 1'b1;
      end
      // NOP and the illegal opcodes leave the word at zero
      default: ;
    endcase
    return {input_sel, wren, write_ad, adr_mux, write, pc_load,
            spr_w, spr_i, spr_d, cond, op2, sw, mad_mux};
  endfunction

  // Register two advances when it is empty or being drained this cycle
  assign r2_load   = r1_valid && (!r2_valid || out.ready);
  assign dec_ready = !r1_valid || r2_load;
  assign r1_load   = dec_valid && dec_ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      r1_valid <= 1'b0;
      r1_word  <= '0;
    end else if (r1_load) begin
      r1_valid <= 1'b1;
      r1_word  <= decode(dec_instr);
    end else if (r2_load) begin
      r1_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      r2_valid <= 1'b0;
      r2_word  <= '0;
    end else if (r2_load) begin
      r2_valid <= 1'b1;
      r2_word  <= r1_word;
    end else if (out.ready) begin
      r2_valid <= 1'b0;
    end
  end

  assign out.valid = r2_valid;
  assign {out.input_sel, out.wren, out.write_ad, out.adr_mux, out.write, out.pc_load,
          out.spr_w, out.spr_i, out.spr_d, out.cond, out.op2, out.sw, out.mad_mux} = r2_word;

  a_r2_copies_r1: assert property (@(posedge CLK) disable iff (!rst_n)
    r2_load |=> (r2_word == $past(r1_word)))
    else $error("register two does not match register one of the previous cycle");

  // Offered word holds until the issue side takes it
  a_hold_on_stall: assert property (@(posedge CLK) disable iff (!rst_n)
    (out.valid && !out.ready) |=> (out.valid && $stable(r2_word)))
    else $error("control word changed while stalled");

endmodule

`default_nettype wire

// File: ctrl_issue.sv
// Execute-side four-phase sender that latches one control word and holds it while offered
`timescale 1ns/1ns
`default_nettype none

module ctrl_issue (
  input  logic                  CLK,
  input  logic                  rst_n,
  ctrl_if.consumer              in,
  output logic                  ex_req,
  input  logic                  ex_ack,
  output logic                  input_sel,
  output logic                  wren,
  output decode_pkg::reg_addr_t write_ad,
  output logic                  adr_mux,
  output logic                  write,
  output logic                  pc_load,
  output logic                  spr_w,
  output logic                  spr_i,
  output logic                  spr_d,
  output decode_pkg::cond_t     cond,
  output decode_pkg::alu_op_t   op2,
  output logic                  sw,
  output logic                  mad_mux
);

  typedef enum logic [1:0] {IDLE, OFFER, WAIT_ACK_LOW} state_t;

  state_t                 state;
  decode_pkg::ctrl_word_t word_q;

  assign in.ready = (state == IDLE);
  assign ex_req   = (state == OFFER);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      word_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (in.valid) begin
            word_q <= {in.input_sel, in.wren, in.write_ad, in.adr_mux, in.write, in.pc_load,
                       in.spr_w, in.spr_i, in.spr_d, in.cond, in.op2, in.sw, in.mad_mux};
            state  <= OFFER;
          end
        end
        OFFER: begin
          if (ex_ack) state <= WAIT_ACK_LOW;
        end
        // Next word only after execute has released its ack
        WAIT_ACK_LOW: begin
          if (!ex_ack) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign {input_sel, wren, write_ad, adr_mux, write, pc_load,
          spr_w, spr_i, spr_d, cond, op2, sw, mad_mux} = word_q;

  a_fields_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    ex_req |=> (!ex_req || $stable(word_q)))
    else $error("execute fields changed while ex_req high");

  a_req_after_ack_low: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(ex_req) |-> !$past(ex_ack))
    else $error("ex_req rose while ex_ack still high");

endmodule

`default_nettype wire

// File: decode_top.sv
// Decode stage top level, wires fetch intake, decoder and execute issue together
`timescale 1ns/1ns
`default_nettype none

module decode_top #(
  parameter int INTAKE_DEPTH = 2
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  instr_req,
  input  decode_pkg::instr_t    instr,
  output logic                  instr_ack,
  output logic                  ex_req,
  input  logic                  ex_ack,
  output logic                  input_sel,
  output logic                  wren,
  output decode_pkg::reg_addr_t write_ad,
  output logic                  adr_mux,
  output logic                  write,
  output logic                  pc_load,
  output logic                  spr_w,
  output logic                  spr_i,
  output logic                  spr_d,
  output decode_pkg::cond_t     cond,
  output decode_pkg::alu_op_t   op2,
  output logic                  sw,
  output logic                  mad_mux
);

  logic               dec_valid;
  logic               dec_ready;
  decode_pkg::instr_t dec_instr;

  ctrl_if ctrl_bus ();

  instr_intake #(
    .INTAKE_DEPTH (INTAKE_DEPTH)
  ) u_intake (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .instr_req (instr_req),
    .instr     (instr),
    .instr_ack (instr_ack),
    .dec_valid (dec_valid),
    .dec_instr (dec_instr),
    .dec_ready (dec_ready)
  );

  control_decoder u_decoder (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_instr (dec_instr),
    .dec_ready (dec_ready),
    .out       (ctrl_bus.producer)
  );

  ctrl_issue u_issue (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .in        (ctrl_bus.consumer),
    .ex_req    (ex_req),
    .ex_ack    (ex_ack),
    .input_sel (input_sel),
    .wren      (wren),
    .write_ad  (write_ad),
    .adr_mux   (adr_mux),
    .write     (write),
    .pc_load   (pc_load),
    .spr_w     (spr_w),
    .spr_i     (spr_i),
    .spr_d     (spr_d),
    .cond      (cond),
    .op2       (op2),
    .sw        (sw),
    .mad_mux   (mad_mux)
  );

endmodule

`default_nettype wire

// File: tb_decode_top.sv
// Self-checking testbench for the decode stage, drives fetch and answers execute over four-phase
`timescale 1ns/1ns
`default_nettype none

module tb_decode_top;

  localparam int N_INSTR        = 60;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int MAX_DELAY      = 6;

  logic                   CLK;
  logic                   rst_n;
  logic                   instr_req;
  decode_pkg::instr_t     instr;
  logic                   instr_ack;
  logic                   ex_req;
  logic                   ex_ack;
  logic                   input_sel;
  logic                   wren;
  decode_pkg::reg_addr_t  write_ad;
  logic                   adr_mux;
  logic                   write;
  logic                   pc_load;
  logic                   spr_w;
  logic                   spr_i;
  logic                   spr_d;
  decode_pkg::cond_t      cond;
  decode_pkg::alu_op_t    op2;
  logic                   sw;
  logic                   mad_mux;

  decode_pkg::ctrl_word_t got_word;
  decode_pkg::ctrl_word_t exp_word;
  decode_pkg::ctrl_word_t exp_queue [$];
  decode_pkg::instr_t     program_words [N_INSTR];
  int unsigned            ack_delays [N_INSTR];
  int unsigned            rand_state;
  int                     received;
  logic                   idle_window;
  logic                   stall_seen;

  always #50 CLK = ~CLK;

  decode_top #(
    .INTAKE_DEPTH (2)
  ) dut (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .instr_req (instr_req),
    .instr     (instr),
    .instr_ack (instr_ack),
    .ex_req    (ex_req),
    .ex_ack    (ex_ack),
    .input_sel (input_sel),
    .wren      (wren),
    .write_ad  (write_ad),
    .adr_mux   (adr_mux),
    .write     (write),
    .pc_load   (pc_load),
    .spr_w     (spr_w),
    .spr_i     (spr_i),
    .spr_d     (spr_d),
    .cond      (cond),
    .op2       (op2),
    .sw        (sw),
    .mad_mux   (mad_mux)
  );

  assign got_word = {input_sel, wren, write_ad, adr_mux, write, pc_load,
                     spr_w, spr_i, spr_d, cond, op2, sw, mad_mux};

  // Counts every control word the DUT offers
  always @(posedge ex_req) begin
    received++;
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Reference decode, built field by field from the opcode table
  function automatic decode_pkg::ctrl_word_t expected_word(input decode_pkg::instr_t ins);
    decode_pkg::opcode_t   opc;
    decode_pkg::reg_addr_t dst;
    logic                  is_push;
    logic                  is_pop;
    logic                  writes_reg;
    logic                  is_jump;
    logic                  is_alu;
    opc        = ins[15:12];
    dst        = ins[11:9];
    is_push    = (opc == decode_pkg::OP_PUSH);
    is_pop     = (opc == decode_pkg::OP_POP);
    is_jump    = (opc == decode_pkg::OP_JUMP);
    is_alu     = (opc == decode_pkg::OP_ALU);
    writes_reg = is_alu || is_pop || (opc == decode_pkg::OP_LOAD) || (opc == decode_pkg::OP_IN);
    return {opc == decode_pkg::OP_IN,
            writes_reg,
            writes_reg ? dst : 3'd0,
            (opc == decode_pkg::OP_LOAD) || (opc == decode_pkg::OP_STORE),
            (opc == decode_pkg::OP_STORE) || is_push,
            is_jump,
            is_push || is_pop,
            is_pop,
            is_push,
            is_jump ? ins[8:6] : 3'd0,
            is_alu ? ins[5:3] : 3'd0,
            is_push,
            (opc == decode_pkg::OP_LOAD) || is_pop};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_field(input string name, input decode_pkg::ctrl_word_t got,
                               input decode_pkg::ctrl_word_t exp, input int lsb, input int width);
    int unsigned g;
    int unsigned e;
    g = (32'(got) >> lsb) & ((32'd1 << width) - 32'd1);
    e = (32'(exp) >> lsb) & ((32'd1 << width) - 32'd1);
    if (g != e) begin
      abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, g, e));
    end
  endtask

  // Names the first field that differs
  task automatic report_word_mismatch(input decode_pkg::ctrl_word_t got,
                                      input decode_pkg::ctrl_word_t exp);
    compare_field("input_sel", got, exp, 18, 1);
    compare_field("wren", got, exp, 17, 1);
    compare_field("write_ad", got, exp, 14, 3);
    compare_field("adr_mux", got, exp, 13, 1);
    compare_field("write", got, exp, 12, 1);
    compare_field("pc_load", got, exp, 11, 1);
    compare_field("spr_w", got, exp, 10, 1);
    compare_field("spr_i", got, exp, 9, 1);
    compare_field("spr_d", got, exp, 8, 1);
    compare_field("cond", got, exp, 5, 3);
    compare_field("op2", got, exp, 2, 3);
    compare_field("sw", got, exp, 1, 1);
    compare_field("mad_mux", got, exp, 0, 1);
    abort_run($sformatf("CHECK FAILED control word got 0x%0h expected 0x%0h", got, exp));
  endtask

  task automatic wait_signal(input bit on_ex_req, input logic level, input string what,
                             output int cycles);
    cycles = 0;
    while ((on_ex_req ? ex_req : instr_ack) !== level) begin
      @(negedge CLK);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run($sformatf("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what));
      end
    end
  endtask

  task automatic run_fetch();
    int cycles;
    for (int i = 0; i < N_INSTR; i++) begin
      exp_queue.push_back(expected_word(program_words[i]));
      instr     = program_words[i];
      instr_req = 1'b1;
      wait_signal(1'b0, 1'b1, "instr_ack to rise", cycles);
      // A normal ack comes after one cycle, longer means the intake was full
      if (cycles > 1) begin
        stall_seen = 1'b1;
      end
      instr_req = 1'b0;
      wait_signal(1'b0, 1'b0, "instr_ack to fall", cycles);
    end
  endtask

  task automatic run_execute();
    int cycles;
    for (int n = 0; n < N_INSTR; n++) begin
      wait_signal(1'b1, 1'b1, "ex_req to rise", cycles);
      if (exp_queue.size() == 0) begin
        abort_run("ex_req offered a control word while none was expected");
      end
      exp_word = exp_queue.pop_front();
      repeat (ack_delays[n]) @(negedge CLK);
      ex_ack = 1'b1;
      wait_signal(1'b1, 1'b0, "ex_req to fall", cycles);
      ex_ack = 1'b0;
    end
  endtask

  a_idle_after_reset: assert property (@(posedge CLK) disable iff (!rst_n)
    idle_window |-> (!instr_ack && !ex_req && got_word == '0))
    else abort_run($sformatf(
      "CHECK FAILED idle outputs instr_ack 0x%0h ex_req 0x%0h word 0x%0h expected 0x0",
      instr_ack, ex_req, got_word));

  a_word_matches: assert property (@(posedge CLK) disable iff (!rst_n)
    ex_req |-> (got_word == exp_word))
    else report_word_mismatch(got_word, exp_word);

  a_fields_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    ($past(ex_req) && ex_req) |-> $stable(got_word))
    else abort_run("Control fields changed while ex_req was held high");

  // Four-phase ordering on both sides
  a_ack_rise: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(instr_ack) |-> $past(instr_req))
    else abort_run("instr_ack rose while instr_req was low");

  a_ack_fall: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(instr_ack) |-> !$past(instr_req))
    else abort_run("instr_ack fell before instr_req was dropped");

  a_req_fall: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(ex_req) |-> $past(ex_ack))
    else abort_run("ex_req fell before ex_ack was raised");

  a_req_rise: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(ex_req) |-> !$past(ex_ack))
    else abort_run("ex_req rose again before ex_ack was dropped");

  initial begin
    decode_pkg::opcode_t opc;
    CLK         = 1'b0;
    rst_n       = 1'b0;
    instr_req   = 1'b0;
    instr       = '0;
    ex_ack      = 1'b0;
    exp_word    = '0;
    received    = 0;
    idle_window = 1'b0;
    stall_seen  = 1'b0;
    rand_state  = 32'd77;
    // First 16 words walk every opcode, legal and illegal
    for (int i = 0; i < N_INSTR; i++) begin
      rand_state = lcg_next(rand_state);
      opc = (i < 16) ? 4'(i) : rand_state[31:28];
      program_words[i] = {opc, rand_state[27:16]};
      rand_state = lcg_next(rand_state);
      ack_delays[i] = (rand_state >> 16) % 32'(MAX_DELAY + 1);
    end
    repeat (5) @(negedge CLK);
    rst_n       = 1'b1;
    idle_window = 1'b1;
    repeat (3) @(negedge CLK);
    idle_window = 1'b0;
    fork
      run_fetch();
      run_execute();
    join
    repeat (20) @(negedge CLK);
    if (received != N_INSTR) begin
      abort_run($sformatf("CHECK FAILED received got 0x%0h expected 0x%0h", received, N_INSTR));
    end else if (ex_req !== 1'b0) begin
      abort_run("An extra control word was offered after the last instruction");
    end else if (!stall_seen) begin
      abort_run("Fetch was never held off by execute back-pressure");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: src.f
decode_pkg.sv
ctrl_if.sv
instr_intake.sv
control_decoder.sv
ctrl_issue.sv
decode_top.sv
tb_decode_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_decode_top
FILELIST  := src.f
BUILD_DIR := obj_dir

SRCS := $(shell cat $(FILELIST))

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
